//--- rtl/lm_addr_pkg.sv
// Physical address layout for the load monitor
// Assumes 64-byte cache lines and a 256-set data cache, so the
// index is address bits 13 to 6; a different cache geometry needs
// idx_width and line_lsb changed together
`default_nettype none

package lm_addr_pkg;

  //==============================
  // Field positions
  //==============================
  localparam int pa_width  = 40;
  localparam int line_lsb  = 6;
  localparam int idx_width = 8;

  //==============================
  // Address types
  //==============================
  // Full physical address
  typedef logic [pa_width-1:0]          pa_t;

  // Line number, address bits above the line offset
  typedef logic [pa_width-line_lsb-1:0] line_t;

  // Cache set index
  typedef logic [idx_width-1:0]         idx_t;

endpackage : lm_addr_pkg

`default_nettype wire

//--- rtl/lm_ctrl_pkg.sv
// Control encodings for the load monitor
// The state encoding keeps bit 2 clear only in idle, so any
// held reservation can be seen from the top bit alone
// Bus response codes follow the AXI RRESP encoding
`default_nettype none

package lm_ctrl_pkg;

  localparam int size_width  = 3;
  localparam int bus_id_width = 5;

  //==============================
  // Reservation state
  //==============================
  typedef enum logic [2:0] {
    idle         = 3'b000,
    wait_req     = 3'b100,
    wait_resp    = 3'b101,
    ex_wait_lock = 3'b110,
    amo_lock     = 3'b111
  } lm_state_t;

  //==============================
  // Bus response
  //==============================
  // Only slverr is treated as a failed read
  typedef enum logic [1:0] {
    okay   = 2'b00,
    exokay = 2'b01,
    slverr = 2'b10,
    decerr = 2'b11
  } resp_t;

  typedef logic [size_width-1:0]   size_t;
  typedef logic [bus_id_width-1:0] bus_id_t;

endpackage : lm_ctrl_pkg

`default_nettype wire

//--- rtl/lm_resv_if.sv
// Link between the reservation register and the state machine
// All signals are level status within one lm_clk cycle, with no
// handshake; the register side reports hits and responses, the
// state machine side reports the current state
`timescale 1ns/1ps
`default_nettype none

interface lm_resv_if;

  import lm_ctrl_pkg::*;

  // Hits on the reserved line this cycle
  logic      snoop_hit;
  logic      evict_hit;

  // Sticky hits seen while the request was outstanding
  logic      already_snoop;
  logic      already_evict;

  // Matching bus response, split on slverr
  logic      resp_ok;
  logic      resp_err;

  // Reservation came from an LR, not an AMO
  logic      lr;

  lm_state_t state;

  modport resv (
    output snoop_hit,
    output evict_hit,
    output already_snoop,
    output already_evict,
    output resp_ok,
    output resp_err,
    output lr,
    input  state
  );

  modport fsm (
    input  snoop_hit,
    input  evict_hit,
    input  already_snoop,
    input  already_evict,
    input  resp_ok,
    input  resp_err,
    input  lr,
    output state
  );

endinterface : lm_resv_if

`default_nettype wire

//--- rtl/lm_resv_reg.sv
// Reservation register of the load monitor
// Holds one reservation only; a new init_vld overwrites it in any state
// Reserved address, size, LR flag and bus id have no reset and are
// only meaningful once the state machine has left idle
`timescale 1ns/1ps
`default_nettype none

module lm_resv_reg (
  input  wire                   lm_clk,
  input  wire                   cpurst_b,
  // Reservation start
  input  wire                   init_vld,
  input  lm_addr_pkg::pa_t      init_pa,
  input  lm_ctrl_pkg::size_t    init_size,
  input  wire                   init_lr,
  // Bus request and response
  input  wire                   req_issued,
  input  lm_ctrl_pkg::bus_id_t  req_id,
  input  wire                   r_vld,
  input  lm_ctrl_pkg::bus_id_t  r_id,
  input  lm_ctrl_pkg::resp_t    r_resp,
  // Line hits
  input  wire                   snoop_inv_vld,
  input  lm_addr_pkg::line_t    snoop_line,
  input  wire                   victim_vld,
  input  lm_addr_pkg::line_t    victim_line,
  // SC check
  input  lm_addr_pkg::pa_t      sc_pa,
  input  lm_ctrl_pkg::size_t    sc_size,
  lm_resv_if.resv               resv,
  output logic                  sc_fail,
  output lm_addr_pkg::pa_t      resv_pa
);

  import lm_addr_pkg::*;
  import lm_ctrl_pkg::*;

  pa_t     resv_addr;
  size_t   resv_size;
  logic    resv_lr;
  bus_id_t resv_id;
  line_t   resv_line;
  logic    mnt_snq;
  logic    id_hit;

  //==============================
  // Reservation payload
  //==============================
  always_ff @(posedge lm_clk)
  begin
    if (init_vld)
    begin
      resv_addr <= init_pa;
      resv_size <= init_size;
      resv_lr   <= init_lr;
    end
  end

  // Id of the outstanding read
  always_ff @(posedge lm_clk)
  begin
    if (req_issued)
      resv_id <= req_id;
  end

  assign resv_line = resv_addr[pa_width-1:line_lsb];
  assign resv_pa   = resv_addr;
  assign resv.lr   = resv_lr;

  //==============================
  // Line and response matching
  //==============================
  assign resv.snoop_hit = snoop_inv_vld && (snoop_line == resv_line);
  assign resv.evict_hit = victim_vld && (victim_line == resv_line);

  assign id_hit        = r_vld && (r_id == resv_id);
  assign resv.resp_ok  = id_hit && (r_resp != slverr);
  assign resv.resp_err = id_hit && (r_resp == slverr);

  //==============================
  // Sticky hit flags
  //==============================
  // Snoops are watched while the read is pending in either wait state
  assign mnt_snq = (resv.state == wait_req) || (resv.state == wait_resp);

  always_ff @(posedge lm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      resv.already_snoop <= 1'b0;
    else if (init_vld)
      resv.already_snoop <= 1'b0;
    else if (mnt_snq && resv.snoop_hit)
      resv.already_snoop <= 1'b1;
  end

  // Evictions only matter before the request has gone out
  always_ff @(posedge lm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      resv.already_evict <= 1'b0;
    else if (init_vld)
      resv.already_evict <= 1'b0;
    else if ((resv.state == wait_req) && resv.evict_hit)
      resv.already_evict <= 1'b1;
  end

  //==============================
  // Store-conditional check
  //==============================
  // Pass needs the LR lock plus an exact address and size match
  assign sc_fail = (resv.state != ex_wait_lock)
                   || (sc_pa != resv_addr)
                   || (sc_size != resv_size);

endmodule : lm_resv_reg

`default_nettype wire

//--- rtl/lm_state_fsm.sv
// Reservation state machine of the load monitor
// One transition per lm_clk edge; flush wins over every other input
// and returns to idle on the next edge
// Callers must not raise no_req and req_issued in the same cycle;
// no_req is taken first if they do
`timescale 1ns/1ps
`default_nettype none

module lm_state_fsm (
  input  wire     lm_clk,
  input  wire     cpurst_b,
  input  wire     init_vld,
  input  wire     no_req,
  input  wire     req_issued,
  input  wire     lock_clr,
  input  wire     flush,
  lm_resv_if.fsm  resv
);

  import lm_ctrl_pkg::*;

  lm_state_t state;
  lm_state_t next_state;
  logic      line_lost;

  //==============================
  // State register
  //==============================
  always_ff @(posedge lm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      state <= idle;
    else if (flush)
      state <= idle;
    else
      state <= next_state;
  end

  assign resv.state = state;

  // Reserved line was snooped or evicted before the request resolved
  assign line_lost = resv.already_snoop || resv.snoop_hit
                     || resv.already_evict || resv.evict_hit;

  //==============================
  // Next state
  //==============================
  always_comb
  begin
    next_state = state;
    case (state)
      idle:
      begin
        if (init_vld)
          next_state = wait_req;
      end
      wait_req:
      begin
        // Request skipped, line already in cache
        if (no_req)
          next_state = line_lost ? idle : ex_wait_lock;
        else if (req_issued)
          next_state = wait_resp;
      end
      wait_resp:
      begin
        if (resv.resp_err)
          next_state = idle;
        else if (resv.resp_ok)
          next_state = resv.lr ? ex_wait_lock : amo_lock;
      end
      ex_wait_lock:
      begin
        // A new LR replaces the current reservation
        if (init_vld)
          next_state = wait_req;
        else if (resv.snoop_hit || lock_clr || resv.evict_hit)
          next_state = idle;
      end
      amo_lock:
      begin
        if (lock_clr)
          next_state = idle;
      end
      default:
      begin
        next_state = idle;
      end
    endcase
  end

endmodule : lm_state_fsm

`default_nettype wire

//--- rtl/lm_idx_guard.sv
// Cache index guard for the AMO lock
// Purely combinational; each requester is compared on its own,
// so several hits may be high in the same cycle
`timescale 1ns/1ps
`default_nettype none

module lm_idx_guard #(
  parameter int num_req = 3
) (
  input  lm_addr_pkg::idx_t  lock_idx,
  input  wire                locked,
  input  lm_addr_pkg::idx_t  req_idx [num_req],
  output logic [num_req-1:0] hit
);

  // One comparator per requester
  always_comb
  begin
    for (int i = 0; i < num_req; i++)
    begin
      hit[i] = locked && (req_idx[i] == lock_idx);
    end
  end

endmodule : lm_idx_guard

`default_nettype wire

//--- rtl/lm_top.sv
// Load-reservation monitor top level
// Single reservation, single clock lm_clk, asynchronous active-low reset
// No back-pressure; all outputs are status only
// lm_state changes one cycle after the sampling edge, the other outputs
// are combinational from registered state and the current inputs
`timescale 1ns/1ps
`default_nettype none

module lm_top (
  input  wire                    lm_clk,
  input  wire                    cpurst_b,
  // Reservation start
  input  wire                    init_vld,
  input  lm_addr_pkg::pa_t       init_pa,
  input  lm_ctrl_pkg::size_t     init_size,
  input  wire                    init_lr,
  // Bus request and response
  input  wire                    req_issued,
  input  lm_ctrl_pkg::bus_id_t   req_id,
  input  wire                    no_req,
  input  wire                    r_vld,
  input  lm_ctrl_pkg::bus_id_t   r_id,
  input  lm_ctrl_pkg::resp_t     r_resp,
  // Line hits
  input  wire                    snoop_inv_vld,
  input  lm_addr_pkg::line_t     snoop_line,
  input  wire                    victim_vld,
  input  lm_addr_pkg::line_t     victim_line,
  // Control
  input  wire                    lock_clr,
  input  wire                    flush,
  // SC check
  input  lm_addr_pkg::pa_t       sc_pa,
  input  lm_ctrl_pkg::size_t     sc_size,
  // Index queries
  input  lm_addr_pkg::idx_t      ld_idx,
  input  lm_addr_pkg::pa_t       st_pa,
  input  lm_addr_pkg::pa_t       snq_pa,
  // Status
  output logic                   sc_fail,
  output logic                   ld_hit_idx,
  output logic                   st_hit_idx,
  output logic                   snq_stall,
  output lm_ctrl_pkg::lm_state_t lm_state
);

  import lm_addr_pkg::*;
  import lm_ctrl_pkg::*;

  pa_t        resv_pa;
  idx_t       req_idx [3];
  logic [2:0] idx_hit;
  logic       locked;

  lm_resv_if resv_if ();

  //==============================
  // Reservation and state
  //==============================
  lm_resv_reg u_resv_reg (
    .lm_clk        (lm_clk),
    .cpurst_b      (cpurst_b),
    .init_vld      (init_vld),
    .init_pa       (init_pa),
    .init_size     (init_size),
    .init_lr       (init_lr),
    .req_issued    (req_issued),
    .req_id        (req_id),
    .r_vld         (r_vld),
    .r_id          (r_id),
    .r_resp        (r_resp),
    .snoop_inv_vld (snoop_inv_vld),
    .snoop_line    (snoop_line),
    .victim_vld    (victim_vld),
    .victim_line   (victim_line),
    .sc_pa         (sc_pa),
    .sc_size       (sc_size),
    .resv          (resv_if.resv),
    .sc_fail       (sc_fail),
    .resv_pa       (resv_pa)
  );

  lm_state_fsm u_state_fsm (
    .lm_clk     (lm_clk),
    .cpurst_b   (cpurst_b),
    .init_vld   (init_vld),
    .no_req     (no_req),
    .req_issued (req_issued),
    .lock_clr   (lock_clr),
    .flush      (flush),
    .resv       (resv_if.fsm)
  );

  assign lm_state = resv_if.state;

  //==============================
  // AMO lock index guard
  //==============================
  assign locked = (resv_if.state == amo_lock);

  // Requester order is load, store, snoop
  assign req_idx[0] = ld_idx;
  assign req_idx[1] = st_pa[line_lsb +: idx_width];
  assign req_idx[2] = snq_pa[line_lsb +: idx_width];

  lm_idx_guard #(
    .num_req (3)
  ) u_idx_guard (
    .lock_idx (resv_pa[line_lsb +: idx_width]),
    .locked   (locked),
    .req_idx  (req_idx),
    .hit      (idx_hit)
  );

  assign ld_hit_idx = idx_hit[0];
  assign st_hit_idx = idx_hit[1];
  assign snq_stall  = idx_hit[2];

endmodule : lm_top

`default_nettype wire

//--- testbench/lm_model.sv
// Cycle-level reference model of the load monitor
// Line and cache index are taken at fixed address bits,
// 39 to 6 for the line and 13 to 6 for the index
`timescale 1ns/1ps
`default_nettype none

module lm_model (
  input  wire                    lm_clk,
  input  wire                    cpurst_b,
  input  wire                    init_vld,
  input  lm_addr_pkg::pa_t       init_pa,
  input  lm_ctrl_pkg::size_t     init_size,
  input  wire                    init_lr,
  input  wire                    req_issued,
  input  lm_ctrl_pkg::bus_id_t   req_id,
  input  wire                    no_req,
  input  wire                    r_vld,
  input  lm_ctrl_pkg::bus_id_t   r_id,
  input  lm_ctrl_pkg::resp_t     r_resp,
  input  wire                    snoop_inv_vld,
  input  lm_addr_pkg::line_t     snoop_line,
  input  wire                    victim_vld,
  input  lm_addr_pkg::line_t     victim_line,
  input  wire                    lock_clr,
  input  wire                    flush,
  input  lm_addr_pkg::pa_t       sc_pa,
  input  lm_ctrl_pkg::size_t     sc_size,
  input  lm_addr_pkg::idx_t      ld_idx,
  input  lm_addr_pkg::pa_t       st_pa,
  input  lm_addr_pkg::pa_t       snq_pa,
  output logic                   sc_fail,
  output logic                   ld_hit_idx,
  output logic                   st_hit_idx,
  output logic                   snq_stall,
  output lm_ctrl_pkg::lm_state_t lm_state
);

  import lm_addr_pkg::*;
  import lm_ctrl_pkg::*;

  lm_state_t cur;
  lm_state_t nxt;
  pa_t       held_pa;
  size_t     held_size;
  logic      held_lr;
  bus_id_t   held_id;
  logic      seen_snoop;
  logic      seen_evict;
  logic      snoop_now;
  logic      evict_now;
  logic      resp_match;

  // Line is address bits 39 to 6
  assign snoop_now  = snoop_inv_vld && (snoop_line == held_pa[39:6]);
  assign evict_now  = victim_vld && (victim_line == held_pa[39:6]);
  assign resp_match = r_vld && (r_id == held_id);

  always_comb
  begin
    nxt = cur;
    case (cur)
      idle:
        if (init_vld)
          nxt = wait_req;
      wait_req:
        if (no_req)
          nxt = (seen_snoop || snoop_now || seen_evict || evict_now) ? idle : ex_wait_lock;
        else if (req_issued)
          nxt = wait_resp;
      wait_resp:
        if (resp_match && (r_resp == slverr))
          nxt = idle;
        else if (resp_match)
          nxt = held_lr ? ex_wait_lock : amo_lock;
      ex_wait_lock:
        if (init_vld)
          nxt = wait_req;
        else if (snoop_now || evict_now || lock_clr)
          nxt = idle;
      amo_lock:
        if (lock_clr)
          nxt = idle;
      default:
        nxt = idle;
    endcase
  end

  always_ff @(posedge lm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      cur        <= idle;
      held_pa    <= '0;
      held_size  <= '0;
      held_lr    <= 1'b0;
      held_id    <= '0;
      seen_snoop <= 1'b0;
      seen_evict <= 1'b0;
    end
    else
    begin
      cur <= flush ? idle : nxt;
      if (init_vld)
      begin
        held_pa    <= init_pa;
        held_size  <= init_size;
        held_lr    <= init_lr;
        seen_snoop <= 1'b0;
        seen_evict <= 1'b0;
      end
      else
      begin
        if (snoop_now && ((cur == wait_req) || (cur == wait_resp)))
          seen_snoop <= 1'b1;
        if (evict_now && (cur == wait_req))
          seen_evict <= 1'b1;
      end
      if (req_issued)
        held_id <= req_id;
    end
  end

  assign lm_state   = cur;
  assign sc_fail    = !((cur == ex_wait_lock) && (sc_pa == held_pa) && (sc_size == held_size));
  assign ld_hit_idx = (cur == amo_lock) && (ld_idx == held_pa[13:6]);
  assign st_hit_idx = (cur == amo_lock) && (st_pa[13:6] == held_pa[13:6]);
  assign snq_stall  = (cur == amo_lock) && (snq_pa[13:6] == held_pa[13:6]);

endmodule : lm_model

`default_nettype wire

//--- testbench/lm_tb.sv
// Testbench for the load-reservation monitor
// Directed LR, AMO, eviction and flush sequences, then seeded random
// stimulus; outputs are compared with lm_model at every falling edge
`timescale 1ns/1ps
`default_nettype none

module lm_tb;

  import lm_addr_pkg::*;
  import lm_ctrl_pkg::*;

  localparam int period_ns  = 100;
  localparam int num_cycles = 4000;
  // Reset, directed part and random part, plus some slack
  localparam int run_cycles = 10 + 60 + num_cycles;

  logic lm_clk;
  logic cpurst_b;
  logic init_vld;
  pa_t init_pa;
  size_t init_size;
  logic init_lr;
  logic req_issued;
  bus_id_t req_id;
  logic no_req;
  logic r_vld;
  bus_id_t r_id;
  resp_t r_resp;
  logic snoop_inv_vld;
  line_t snoop_line;
  logic victim_vld;
  line_t victim_line;
  logic lock_clr;
  logic flush;
  pa_t sc_pa;
  size_t sc_size;
  idx_t ld_idx;
  pa_t st_pa;
  pa_t snq_pa;
  logic sc_fail;
  logic ld_hit_idx;
  logic st_hit_idx;
  logic snq_stall;
  lm_state_t lm_state;
  logic exp_sc_fail;
  logic exp_ld_hit;
  logic exp_st_hit;
  logic exp_snq_stall;
  lm_state_t exp_state;

  integer seed;
  int errors;
  int checks;
  pa_t lr_pa;
  pa_t amo_pa;

  lm_top dut0 (.*);

  lm_model model0 (
    .*,
    .sc_fail    (exp_sc_fail),
    .ld_hit_idx (exp_ld_hit),
    .st_hit_idx (exp_st_hit),
    .snq_stall  (exp_snq_stall),
    .lm_state   (exp_state)
  );

  always #(period_ns / 2) lm_clk = ~lm_clk;

  // Eight addresses; bit 2 of sel changes the line but keeps the index
  function automatic pa_t pool_pa(input logic [2:0] sel, input logic [1:0] off);
    pool_pa = {25'h200, sel[2], 3'b101, sel[1:0], 3'b011, 4'd0, off};
  endfunction

  task automatic compare_value(input string name, input logic [39:0] got,
                               input logic [39:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic check_outputs;
    compare_value("lm_state", 40'(lm_state), 40'(exp_state));
    compare_value("sc_fail", 40'(sc_fail), 40'(exp_sc_fail));
    compare_value("ld_hit_idx", 40'(ld_hit_idx), 40'(exp_ld_hit));
    compare_value("st_hit_idx", 40'(st_hit_idx), 40'(exp_st_hit));
    compare_value("snq_stall", 40'(snq_stall), 40'(exp_snq_stall));
  endtask

  task automatic clear_inputs;
    init_vld      = 1'b0;
    init_pa       = '0;
    init_size     = '0;
    init_lr       = 1'b0;
    req_issued    = 1'b0;
    req_id        = '0;
    no_req        = 1'b0;
    r_vld         = 1'b0;
    r_id          = '0;
    r_resp        = okay;
    snoop_inv_vld = 1'b0;
    snoop_line    = '0;
    victim_vld    = 1'b0;
    victim_line   = '0;
    lock_clr      = 1'b0;
    flush         = 1'b0;
    sc_pa         = '0;
    sc_size       = '0;
    ld_idx        = '0;
    st_pa         = '0;
    snq_pa        = '0;
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle;
    @(posedge lm_clk);
    #1;
    clear_inputs;
  endtask

  task automatic start_resv(input pa_t pa, input size_t size, input logic lr);
    next_cycle;
    init_vld  = 1'b1;
    init_pa   = pa;
    init_size = size;
    init_lr   = lr;
  endtask

  task automatic issue_req(input bus_id_t id);
    next_cycle;
    req_issued = 1'b1;
    req_id     = id;
  endtask

  task automatic send_resp(input bus_id_t id, input resp_t resp);
    next_cycle;
    r_vld  = 1'b1;
    r_id   = id;
    r_resp = resp;
  endtask

  task automatic expect_state(input lm_state_t exp);
    @(negedge lm_clk);
    compare_value("lm_state", 40'(lm_state), 40'(exp));
  endtask

  // Rare control events, frequent hits on a small pool of lines and ids
  task automatic drive_random;
    logic [31:0] r;
    logic [31:0] v;
    pa_t tmp;
    r = $random(seed);
    v = $random(seed);
    init_vld      = (r[3:0] == 4'd0);
    init_lr       = r[4];
    req_issued    = (r[6:5] == 2'd0);
    no_req        = (r[9:7] == 3'd0);
    r_vld         = (r[11:10] == 2'd0);
    r_resp        = resp_t'(r[13:12]);
    snoop_inv_vld = (r[16:14] == 3'd0);
    victim_vld    = (r[19:17] == 3'd0);
    lock_clr      = (r[23:20] == 4'd0);
    flush         = (r[28:24] == 5'd0);
    init_pa       = pool_pa(v[2:0], v[4:3]);
    init_size     = {2'b01, v[5]};
    req_id        = {3'b000, v[7:6]};
    r_id          = {3'b000, v[9:8]};
    tmp           = pool_pa(v[12:10], 2'd0);
    snoop_line    = tmp[39:6];
    tmp           = pool_pa(v[15:13], 2'd0);
    victim_line   = tmp[39:6];
    sc_pa         = pool_pa(v[18:16], v[20:19]);
    sc_size       = {2'b01, v[21]};
    tmp           = pool_pa(v[24:22], 2'd0);
    ld_idx        = tmp[13:6];
    st_pa         = pool_pa(v[27:25], 2'd1);
    snq_pa        = pool_pa(v[30:28], 2'd3);
  endtask

  always @(negedge lm_clk)
  begin
    if (cpurst_b)
      check_outputs;
  end

  // Watchdog
  initial
  begin
    #(run_cycles * period_ns);
    $display("Timeout: the run did not finish within %0d cycles", run_cycles);
    $display("TB FAILED");
    $finish;
  end

  initial
  begin
    seed     = 33;
    errors   = 0;
    checks   = 0;
    lm_clk   = 1'b0;
    cpurst_b = 1'b0;
    lr_pa    = pool_pa(3'd1, 2'd2);
    amo_pa   = pool_pa(3'd2, 2'd0);
    clear_inputs;
    repeat (10) @(posedge lm_clk);
    #1;
    cpurst_b = 1'b1;

    //==============================
    // Reset values
    //==============================
    expect_state(idle);
    compare_value("sc_fail", 40'(sc_fail), 40'd1);
    compare_value("ld_hit_idx", 40'(ld_hit_idx), 40'd0);
    compare_value("st_hit_idx", 40'(st_hit_idx), 40'd0);
    compare_value("snq_stall", 40'(snq_stall), 40'd0);

    //==============================
    // LR path, SC check, flush
    //==============================
    start_resv(lr_pa, 3'd3, 1'b1);
    issue_req(5'd9);
    expect_state(wait_req);
    send_resp(5'd9, okay);
    expect_state(wait_resp);
    next_cycle;
    sc_pa   = lr_pa;
    sc_size = 3'd3;
    expect_state(ex_wait_lock);
    compare_value("sc_fail", 40'(sc_fail), 40'd0);
    next_cycle;
    sc_pa   = lr_pa;
    sc_size = 3'd2;
    expect_state(ex_wait_lock);
    compare_value("sc_fail", 40'(sc_fail), 40'd1);
    next_cycle;
    sc_pa   = lr_pa ^ 40'h1;
    sc_size = 3'd3;
    expect_state(ex_wait_lock);
    compare_value("sc_fail", 40'(sc_fail), 40'd1);
    next_cycle;
    flush = 1'b1;
    next_cycle;
    expect_state(idle);

    // Eviction of the reserved line before no_req
    start_resv(lr_pa, 3'd3, 1'b1);
    next_cycle;
    victim_vld  = 1'b1;
    victim_line = lr_pa[39:6];
    expect_state(wait_req);
    next_cycle;
    no_req = 1'b1;
    expect_state(wait_req);
    next_cycle;
    expect_state(idle);

    // Slave error ends the AMO read
    start_resv(amo_pa, 3'd2, 1'b0);
    issue_req(5'd4);
    send_resp(5'd4, slverr);
    next_cycle;
    expect_state(idle);

    //==============================
    // AMO lock and index guard
    //==============================
    start_resv(amo_pa, 3'd2, 1'b0);
    issue_req(5'd4);
    // Response with a wrong id is ignored
    send_resp(5'd6, okay);
    expect_state(wait_resp);
    send_resp(5'd4, okay);
    expect_state(wait_resp);
    next_cycle;
    ld_idx = amo_pa[13:6];
    st_pa  = pool_pa(3'd6, 2'd1);
    snq_pa = lr_pa;
    expect_state(amo_lock);
    compare_value("ld_hit_idx", 40'(ld_hit_idx), 40'd1);
    compare_value("st_hit_idx", 40'(st_hit_idx), 40'd1);
    compare_value("snq_stall", 40'(snq_stall), 40'd0);
    next_cycle;
    lock_clr = 1'b1;
    next_cycle;
    expect_state(idle);

    //==============================
    // Random run against the model
    //==============================
    for (int i = 0; i < num_cycles; i++)
    begin
      next_cycle;
      drive_random;
    end
    next_cycle;
    @(negedge lm_clk);

    $display("Closing report: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule : lm_tb

`default_nettype wire

//--- files.f
rtl/lm_addr_pkg.sv
rtl/lm_ctrl_pkg.sv
rtl/lm_resv_if.sv
rtl/lm_resv_reg.sv
rtl/lm_state_fsm.sv
rtl/lm_idx_guard.sv
rtl/lm_top.sv
testbench/lm_model.sv
testbench/lm_tb.sv

//--- Makefile
# Verilator build and run for the load-reservation monitor

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build lm_tb with Verilator, run it and check for the pass line"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -j 0 --top-module lm_tb --Mdir obj_dir -f files.f
	@out=$$(./obj_dir/Vlm_tb); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir
